// File: Makefile
# Verilator build, run and lint for the branch resolution block

TOP := tb_branch_unit
OBJ := obj_dir

.PHONY: all lint clean

all: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

$(OBJ)/V$(TOP): all.f source/*.sv source/*.svh sim/*.sv sim/branch_unit_testdata.txt
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir $(OBJ)

lint:
	verilator --lint-only -Wall +incdir+source source/branch_pkg.sv \
		source/branching_flags.sv source/branch_detector.sv \
		source/branch_arbiter.sv source/branch_unit.sv --top-module branch_unit

clean:
	rm -rf $(OBJ) sim.log

// File: all.f
+incdir+source
source/branch_pkg.sv
source/branching_flags.sv
source/branch_detector.sv
source/branch_arbiter.sv
source/branch_unit.sv
sim/tb_branch_unit.sv

// File: sim/branch_unit_testdata.txt
// Columns: kind test thread a b c d e (hex). Issue kind 1: a=pc b=prev_result c=exp_taken
// d=exp_target. Config kind 2: a=slot b=en c=cond d=origin e=target. 3 idle, F end.
1 1 0 010 0000 0 000 0
1 1 3 020 1234 0 000 0
2 2 0 0 1 0 040 100
2 2 1 0 1 1 041 101
2 2 2 0 1 2 042 102
2 2 3 0 1 3 043 103
2 2 4 0 1 4 044 104
2 2 5 0 1 7 045 105
1 2 0 040 8001 1 100 0
1 2 1 041 0000 1 101 0
1 2 1 041 0001 0 000 0
1 2 2 042 0000 0 000 0
1 2 2 042 FFFF 1 102 0
1 2 3 043 0000 1 103 0
1 2 3 043 7FFF 1 103 0
1 2 3 043 8000 0 000 0
1 2 4 044 8000 1 104 0
1 2 4 044 7FFF 0 000 0
1 2 5 045 0002 1 105 0
1 2 5 045 7FFF 0 000 0
2 3 6 0 1 5 046 106
2 3 7 0 1 6 047 107
1 3 6 046 0000 0 000 0
1 3 7 047 FFFF 0 000 0
2 4 1 1 1 0 041 111
2 4 1 3 1 0 041 311
2 4 0 2 1 0 040 200
1 4 1 041 0005 1 111 0
1 4 1 041 0000 1 101 0
1 4 0 040 0003 1 100 0
1 5 2 040 0001 0 000 0
2 5 3 0 0 0 043 1FF
1 5 3 043 0000 0 000 0
1 5 4 045 8000 0 000 0
1 6 0 040 0000 1 100 0
1 6 1 041 0007 1 111 0
1 6 2 042 0000 0 000 0
1 6 3 043 0000 0 000 0
1 6 4 044 FFFE 1 104 0
1 6 5 045 0004 1 105 0
1 6 6 046 0000 0 000 0
1 6 7 047 0000 0 000 0
F 0 0 0 0 0 0 0

// File: sim/tb_branch_unit.sv
/*
  Testbench for the branch resolution top, driven from a hex data file.
  Inputs change on falling edges; outputs are compared three edges later.
  Data lines are eight hex words; the file must end with a kind F line.
*/

`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module tb_branch_unit;
    import branch_pkg::*;

    localparam int FIELDS    = 8;  // Hex words per data line
    localparam int MAX_LINES = 64;
    localparam int LATENCY   = 3;  // Issue to branch, in cycles

    typedef struct packed {
        logic       check;  // Issue line, compare at the output
        logic [7:0] test;
        logic       taken;
        thread_t    thread;
        pc_t        target;
    } expect_t;

    logic                      clock;
    logic                      rst_n;
    thread_ctx_t               issue;
    logic [`BR_WORD_WIDTH-1:0] prev_result;
    cfg_write_t                cfg;
    branch_req_t               branch;

    logic [15:0] data_mem [MAX_LINES*FIELDS]; // Flat copy of the data file
    expect_t     pending [$];                 // One entry per driven cycle
    int          n_lines;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    branch_unit i_branch_unit (
        .clock       (clock),
        .rst_n       (rst_n),
        .issue       (issue),
        .prev_result (prev_result),
        .cfg         (cfg),
        .branch      (branch)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock; // 4 ns period
    end

    function automatic string test_name(input logic [7:0] num);
        case (num)
            8'd1:    return "reset_idle";
            8'd2:    return "conditions";
            8'd3:    return "reserved_conds";
            8'd4:    return "slot_priority";
            8'd5:    return "thread_isolation";
            8'd6:    return "thread_rotation";
            default: return "unknown";
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [7:0] test,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH %s (test %0d) %s: expected %0h actual %0h",
                                test_name(test), test, what, expected, actual));
        end
    endtask

    function automatic logic [15:0] field(input int line, input int idx);
        return data_mem[line*FIELDS + idx];
    endfunction

    // Compare the result of the line driven three falling edges ago
    task automatic check_output();
        expect_t want;
        if (pending.size() == LATENCY) begin
            want = pending.pop_front();
            if (want.check) begin
                check_value("taken", want.test, 32'(want.taken), 32'(branch.taken));
                check_value("thread", want.test, 32'(want.thread), 32'(branch.thread));
                check_value("target", want.test, 32'(want.target), 32'(branch.target));
            end
        end
    endtask

    task automatic drive_idle();
        issue       = '0;  // Bubble, valid low
        cfg         = '0;
        prev_result = '0;
        pending.push_back('0);
    endtask

    task automatic apply_line(input int line);
        expect_t want;
        want = '0;
        drive_idle();
        void'(pending.pop_back()); // Replaced below by this line's entry
        case (field(line, 0))
            16'h1: begin
                issue.valid  = 1'b1;
                issue.thread = thread_t'(field(line, 2));
                issue.pc     = pc_t'(field(line, 3));
                prev_result  = field(line, 4);
                want.check   = 1'b1;
                want.test    = 8'(field(line, 1));
                want.taken   = (field(line, 5) != 16'h0);
                want.thread  = issue.thread;
                want.target  = pc_t'(field(line, 6));
            end
            16'h2: begin
                cfg.we           = 1'b1; // Single cycle strobe
                cfg.thread       = thread_t'(field(line, 2));
                cfg.slot         = slot_t'(field(line, 3));
                cfg.entry.en     = (field(line, 4) != 16'h0);
                cfg.entry.cond   = 3'(field(line, 5));
                cfg.entry.origin = pc_t'(field(line, 6));
                cfg.entry.target = pc_t'(field(line, 7));
            end
            16'h3: begin
                want.check = 1'b0; // Idle cycle
            end
            default: abort_run($sformatf("Unknown line kind in test data at line %0d", line));
        endcase
        pending.push_back(want);
    endtask

    // Run limit from data length, reset and drain
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            abort_run($sformatf("TIMEOUT: run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        int line;
        issue       = '0;
        prev_result = '0;
        cfg         = '0;
        rst_n       = 1'b0;
        $readmemh("sim/branch_unit_testdata.txt", data_mem);
        n_lines = 0;
        while (n_lines < MAX_LINES && field(n_lines, 0) !== 16'hF) begin
            n_lines++;
        end
        if (n_lines == 0 || n_lines == MAX_LINES) begin
            abort_run("Test data missing or has no end marker line");
        end
        cycle_limit = n_lines + 10 + 20;
        repeat (10) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        for (line = 0; line < n_lines; line++) begin
            @(negedge clock);
            check_output();
            apply_line(line);
        end
        repeat (LATENCY) begin // Drain the last issues
            @(negedge clock);
            check_output();
            drive_idle();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/branch_arbiter.sv
/*
  Fixed priority pick among detectors, lowest index wins.
  Output target reads zero when nothing fires.
*/

`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_arbiter (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic [`BR_SLOTS-1:0]                   fire,
    input  logic [`BR_SLOTS-1:0][`BR_PC_WIDTH-1:0] targets,
    input  branch_pkg::thread_ctx_t                ctx,
    output branch_pkg::branch_req_t                branch
);
    import branch_pkg::*;

    logic hit;        // Any slot fired
    pc_t  sel_target; // Target of the winning slot

    // Walk from the top so the lowest firing slot is written last
    always_comb begin
        hit        = 1'b0;
        sel_target = '0;
        for (int s = `BR_SLOTS - 1; s >= 0; s--) begin
            if (fire[s]) begin
                hit        = 1'b1;
                sel_target = targets[s];
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            branch <= '0;
        end else begin
            branch.taken  <= hit && ctx.valid; // Only for a live thread
            branch.thread <= ctx.thread;
            branch.target <= sel_target;       // Zero when no slot fires
        end
    end

    // A taken branch traces back to a detector hit one cycle earlier
    a_taken_src: assert property (
        @(posedge clock) disable iff (!rst_n)
        branch.taken |-> $past(|fire)
    ) else $error("branch taken with no detector firing");

endmodule

`default_nettype wire

// File: source/branch_cfg.svh
/*
  Sizing macros for the branch resolution block.
  Thread and slot counts should stay powers of two; index widths use $clog2.
  Condition select is fixed at 3 bits, so exactly eight flags exist.
*/

`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// Width of an ALU result word
`define BR_WORD_WIDTH 16

// Width of a program counter
`define BR_PC_WIDTH 10

// Threads in the barrel, issued round robin by the core
`define BR_THREADS 8

// Number of branch detectors, lower index wins on a tie
`define BR_SLOTS 4

`endif

// File: source/branch_detector.sv
/*
  One branch detector slot with one entry per thread.
  Config writes land at the rising edge and apply to the next lookup.
  Reset clears every entry, so all slots start disabled.
*/

`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_detector (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic [$clog2(`BR_SLOTS)-1:0]      slot_id,
    input  branch_pkg::cfg_write_t            cfg,
    input  branch_pkg::cond_flags_t           flags,
    input  branch_pkg::thread_ctx_t           flag_ctx,
    output logic                              fire,
    output logic [`BR_PC_WIDTH-1:0]           target,
    output branch_pkg::thread_ctx_t           ctx_out
);
    import branch_pkg::*;

    branch_entry_t entry_tbl [`BR_THREADS]; // Indexed by thread number
    branch_entry_t cur;                     // Entry of the thread in this stage
    logic          wr_hit;                  // Config write aimed at this slot
    logic          pc_match;
    logic          cond_ok;
    logic          fire_next;

    assign wr_hit = cfg.we && (cfg.slot == slot_id);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < `BR_THREADS; t++) begin
                entry_tbl[t] <= '0; // Clears enable
            end
        end else if (wr_hit) begin
            entry_tbl[cfg.thread] <= cfg.entry;
        end
    end

    // Lookup for the thread currently at this stage
    assign cur       = entry_tbl[flag_ctx.thread];
    assign pc_match  = (flag_ctx.pc == cur.origin);
    assign cond_ok   = flags[cur.cond]; // 3 bit select over 8 flags
    assign fire_next = cur.en && flag_ctx.valid && pc_match && cond_ok;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fire    <= 1'b0;
            ctx_out <= '0;
        end else begin
            fire    <= fire_next;
            ctx_out <= flag_ctx; // Keeps context beside fire for the arbiter
        end
    end

    // Target is payload, only meaningful with fire
    always_ff @(posedge clock) begin
        target <= cur.target;
    end

    // Idle slots must stay silent
    a_fire_valid: assert property (
        @(posedge clock) disable iff (!rst_n)
        fire |-> ctx_out.valid
    ) else $error("detector fired on an invalid context");

endmodule

`default_nettype wire

// File: source/branch_pkg.sv
/*
  Shared types for the branch resolution block.
  Flag bit order is fixed; reserved flags 5 and 6 always read low.
*/

`default_nettype none

`include "branch_cfg.svh"

package branch_pkg;

    typedef logic [`BR_PC_WIDTH-1:0]         pc_t;     // Program counter
    typedef logic [$clog2(`BR_THREADS)-1:0]  thread_t; // Thread number
    typedef logic [$clog2(`BR_SLOTS)-1:0]    slot_t;   // Detector index

    // Flag positions inside cond_flags_t
    localparam int FLAG_ALWAYS  = 0;
    localparam int FLAG_ZERO    = 1;
    localparam int FLAG_NONZERO = 2;
    localparam int FLAG_POS     = 3; // Sign clear, zero included
    localparam int FLAG_NEG     = 4;
    localparam int FLAG_RSVD_A  = 5;
    localparam int FLAG_RSVD_B  = 6;
    localparam int FLAG_EVEN    = 7;

    typedef logic [7:0] cond_flags_t;

    typedef struct packed {
        logic       en;     // Entry active
        logic [2:0] cond;   // Index into cond_flags_t
        pc_t        origin; // PC of the branch instruction
        pc_t        target; // Where to go when taken
    } branch_entry_t;

    typedef struct packed {
        logic    valid;
        thread_t thread;
        pc_t     pc;
    } thread_ctx_t;

    typedef struct packed {
        logic          we;     // Single cycle write strobe
        slot_t         slot;
        thread_t       thread;
        branch_entry_t entry;
    } cfg_write_t;

    typedef struct packed {
        logic    taken;
        thread_t thread;
        pc_t     target; // Zero when not taken
    } branch_req_t;

endpackage

`default_nettype wire

// File: source/branch_unit.sv
/*
  Branch resolution top: flags, detector slots, arbiter.
  Fixed three cycle latency from issue to branch, no back-pressure.
  One issue per cycle is accepted unconditionally.
*/

`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_unit (
    input  logic                       clock,
    input  logic                       rst_n,
    input  branch_pkg::thread_ctx_t    issue,
    input  logic [`BR_WORD_WIDTH-1:0]  prev_result,
    input  branch_pkg::cfg_write_t     cfg,
    output branch_pkg::branch_req_t    branch
);
    import branch_pkg::*;

    localparam int SLOT_W = $clog2(`BR_SLOTS);

    cond_flags_t                           flags;
    thread_ctx_t                           flag_ctx;
    logic [`BR_SLOTS-1:0]                  fire;
    logic [`BR_SLOTS-1:0][`BR_PC_WIDTH-1:0] targets;
    thread_ctx_t                           slot_ctx [`BR_SLOTS]; // Same in every slot

    branching_flags i_flags (
        .clock       (clock),
        .rst_n       (rst_n),
        .issue       (issue),
        .prev_result (prev_result),
        .flags       (flags),
        .flag_ctx    (flag_ctx)
    );

    for (genvar s = 0; s < `BR_SLOTS; s++) begin : g_slot
        branch_detector i_detector (
            .clock    (clock),
            .rst_n    (rst_n),
            .slot_id  (SLOT_W'(s)),
            .cfg      (cfg),
            .flags    (flags),
            .flag_ctx (flag_ctx),
            .fire     (fire[s]),
            .target   (targets[s]),
            .ctx_out  (slot_ctx[s])
        );
    end

    branch_arbiter i_arbiter (
        .clock   (clock),
        .rst_n   (rst_n),
        .fire    (fire),
        .targets (targets),
        .ctx     (slot_ctx[0]), // Slot 0 carries the stage context
        .branch  (branch)
    );

endmodule

`default_nettype wire

// File: source/branching_flags.sv
/*
  Condition flags from the previous result of the issuing thread.
  prev_result must already belong to the thread in issue, the core aligns it.
  One cycle of latency; flags and context leave together.
*/

`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branching_flags (
    input  logic                       clock,
    input  logic                       rst_n,
    input  branch_pkg::thread_ctx_t    issue,
    input  logic [`BR_WORD_WIDTH-1:0]  prev_result,
    output branch_pkg::cond_flags_t    flags,
    output branch_pkg::thread_ctx_t    flag_ctx
);
    import branch_pkg::*;

    logic        is_zero;    // Whole word clear
    logic        is_neg;     // Sign bit
    logic        is_even;    // Low bit clear
    cond_flags_t next_flags;

    assign is_zero = (prev_result == '0);
    assign is_neg  = prev_result[`BR_WORD_WIDTH-1];
    assign is_even = ~prev_result[0]; // Hailstone style custom condition

    always_comb begin
        next_flags               = '0;       // Reserved bits stay low
        next_flags[FLAG_ALWAYS]  = 1'b1;
        next_flags[FLAG_ZERO]    = is_zero;
        next_flags[FLAG_NONZERO] = ~is_zero;
        next_flags[FLAG_POS]     = ~is_neg;  // Zero counts as positive
        next_flags[FLAG_NEG]     = is_neg;
        next_flags[FLAG_EVEN]    = is_even;
    end

    // Flags and context move as one stage
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            flags    <= '0;
            flag_ctx <= '0; // Clears valid
        end else begin
            flags    <= next_flags;
            flag_ctx <= issue;
        end
    end

    // No condition select may ever see a reserved flag set
    a_rsvd_low: assert property (
        @(posedge clock) disable iff (!rst_n)
        !flags[FLAG_RSVD_A] && !flags[FLAG_RSVD_B]
    ) else $error("reserved condition flag high");

endmodule

`default_nettype wire
